/* files.f */
+incdir+dv
src/proc_pkg.sv
src/fetch_unit.sv
src/control_unit.sv
src/register_file.sv
src/alu_unit.sv
src/data_memory.sv
src/proc.sv
dv/clock_gen.sv
dv/proc_tb.sv

/* Bender.yml */
package:
  name: proc

sources:
  - files:
      - src/proc_pkg.sv
      - src/fetch_unit.sv
      - src/control_unit.sv
      - src/register_file.sv
      - src/alu_unit.sv
      - src/data_memory.sv
      - src/proc.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/clock_gen.sv
      - dv/proc_tb.sv

/* dv/proc_model.svh */
// Reference model of the single-cycle core
// Architectural registers, memories and a one-instruction step

`ifndef PROC_MODEL_SVH
`define PROC_MODEL_SVH

logic [15:0] m_regs [8];
logic [15:0] m_dmem [256];
logic [15:0] m_imem [256];
logic [15:0] m_pc;
logic        m_halted;
logic        m_err;

function automatic logic is_legal(input logic [4:0] op);
   case (op)
      proc_pkg::op_add, proc_pkg::op_sub, proc_pkg::op_and, proc_pkg::op_xor,
      proc_pkg::op_addi, proc_pkg::op_ld, proc_pkg::op_st, proc_pkg::op_beqz,
      proc_pkg::op_bnez, proc_pkg::op_j, proc_pkg::op_nop, proc_pkg::op_halt:
         return 1'b1;
      default:
         return 1'b0;
   endcase
endfunction

task automatic model_reset();
   m_pc     = '0;
   m_halted = 1'b0;
   m_err    = 1'b0;
   for (int i = 0; i < 8; i++) begin
      m_regs[i] = '0;
   end
endtask

// Executes the instruction at m_pc and returns its retire record
task automatic model_step(output proc_pkg::retire_t exp);
   logic [15:0] ins;
   logic [15:0] rs_v;
   logic [15:0] rt_v;
   logic [15:0] imm;
   logic [15:0] next_pc;
   logic [7:0]  addr;
   logic        wr;
   logic [2:0]  wa;
   logic [15:0] wd;
   ins     = m_imem[m_pc[7:0]];
   rs_v    = m_regs[ins[10:8]];
   rt_v    = m_regs[ins[7:5]];
   imm     = {{11{ins[4]}}, ins[4:0]};
   addr    = 8'(rs_v + imm);
   next_pc = m_pc + 16'd1;
   wr      = 1'b0;
   wa      = ins[4:2];
   wd      = '0;
   exp     = '0;
   exp.valid = 1'b1;
   exp.pc    = m_pc;
   case (ins[15:11])
      proc_pkg::op_add: begin
         wr = 1'b1;
         wd = rs_v + rt_v;
      end
      proc_pkg::op_sub: begin
         wr = 1'b1;
         wd = rs_v - rt_v;
      end
      proc_pkg::op_and: begin
         wr = 1'b1;
         wd = rs_v & rt_v;
      end
      proc_pkg::op_xor: begin
         wr = 1'b1;
         wd = rs_v ^ rt_v;
      end
      proc_pkg::op_addi: begin
         wr = 1'b1;
         wa = ins[7:5];
         wd = rs_v + imm;
      end
      proc_pkg::op_ld: begin
         wr = 1'b1;
         wa = ins[7:5];
         wd = m_dmem[addr];
      end
      proc_pkg::op_st: begin
         exp.mem_write = 1'b1;
         exp.mem_addr  = addr;
         exp.mem_data  = rt_v;
         m_dmem[addr]  = rt_v;
      end
      proc_pkg::op_beqz: begin
         if (rs_v == 16'd0) begin
            next_pc = next_pc + {{8{ins[7]}}, ins[7:0]};
         end
      end
      proc_pkg::op_bnez: begin
         if (rs_v != 16'd0) begin
            next_pc = next_pc + {{8{ins[7]}}, ins[7:0]};
         end
      end
      proc_pkg::op_j:    next_pc = next_pc + {{5{ins[10]}}, ins[10:0]};
      proc_pkg::op_nop:  ;
      proc_pkg::op_halt: m_halted = 1'b1;
      default: begin
         m_halted = 1'b1;
         m_err    = 1'b1;
      end
   endcase
   exp.reg_write = wr;
   if (wr) begin
      exp.reg_addr = wa;
      exp.reg_data = wd;
      m_regs[wa]   = wd;
   end
   m_pc = next_pc;
endtask

`endif

/* dv/proc_tb.sv */
// Testbench for the single-cycle processor
// Loads random programs, preloads data memory and checks every
// retire record against the reference model

`timescale 1ns/1ns

module proc_tb;

   localparam int clk_period   = 4;
   localparam int num_programs = 5;
   localparam int run_retires  = 600;
   localparam int load_cycles  = 300;
   localparam int halt_watch   = 20;
   localparam int wd_limit     = 2 * num_programs * (run_retires + load_cycles) * clk_period;

   // Program kinds in run order
   localparam int prog_alu     = 0;
   localparam int prog_illegal = 1;
   localparam int prog_mem     = 2;
   localparam int prog_halt    = 3;
   localparam int prog_flow    = 4;

   logic              clk;
   logic              reset;
   logic              load_en;
   logic [7:0]        load_addr;
   logic [15:0]       load_data;
   proc_pkg::retire_t retire;
   logic              halted;
   logic              err;
   integer            seed;

   `include "proc_model.svh"

   clock_gen clock_source (.clk(clk));

   proc UUT (
      .clk(clk), .reset(reset),
      .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
      .retire(retire), .halted(halted), .err(err)
   );

   task automatic report_failure();
      $display("TEST FAIL");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_field(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
      assert (actual === expected) else begin
         $display("FAIL time=%0t signal=%s expected=%h actual=%h",
                  $time, name, expected, actual);
         report_failure();
      end
   endtask

   // Straight-line mix for the halt and illegal programs
   function automatic logic [4:0] pick_opcode(input int kind, input int unsigned sel);
      case (kind)
         prog_alu: begin
            case (sel % 5)
               0:       return proc_pkg::op_add;
               1:       return proc_pkg::op_sub;
               2:       return proc_pkg::op_and;
               3:       return proc_pkg::op_xor;
               default: return proc_pkg::op_addi;
            endcase
         end
         prog_mem: begin
            case (sel % 4)
               0:       return proc_pkg::op_ld;
               1:       return proc_pkg::op_st;
               2:       return proc_pkg::op_addi;
               default: return proc_pkg::op_add;
            endcase
         end
         prog_flow: begin
            case (sel % 6)
               0:       return proc_pkg::op_beqz;
               1:       return proc_pkg::op_bnez;
               2:       return proc_pkg::op_j;
               3:       return proc_pkg::op_addi;
               4:       return proc_pkg::op_xor;
               default: return proc_pkg::op_and;
            endcase
         end
         default: begin
            case (sel % 6)
               0:       return proc_pkg::op_add;
               1:       return proc_pkg::op_sub;
               2:       return proc_pkg::op_addi;
               3:       return proc_pkg::op_ld;
               4:       return proc_pkg::op_st;
               default: return proc_pkg::op_nop;
            endcase
         end
      endcase
   endfunction

   function automatic logic [4:0] illegal_opcode();
      logic [4:0] op;
      op = 5'($random(seed));
      while (is_legal(op)) begin
         op = 5'($random(seed));
      end
      return op;
   endfunction

   task automatic build_program(input int kind);
      logic [31:0] r;
      int          stop_at;
      for (int i = 0; i < 256; i++) begin
         r = $random(seed);
         m_imem[i] = {pick_opcode(kind, r[31:28]), r[10:0]};
      end
      if (kind == prog_halt || kind == prog_illegal) begin
         stop_at = 40 + ($unsigned($random(seed)) % 100);
         r = $random(seed);
         if (kind == prog_halt) begin
            m_imem[stop_at] = {proc_pkg::op_halt, r[10:0]};
         end else begin
            m_imem[stop_at] = {illegal_opcode(), r[10:0]};
         end
      end
   endtask

   task automatic load_and_reset();
      logic [15:0] d;
      @(negedge clk);
      reset = 1'b1;
      for (int i = 0; i < 256; i++) begin
         @(negedge clk);
         check_field("retire.valid", retire.valid, 1'b0);
         load_en   = 1'b1;
         load_addr = 8'(i);
         load_data = m_imem[i];
      end
      @(negedge clk);
      load_en = 1'b0;
      repeat (4) @(negedge clk);
      // Data memory has no reset and a store at PC 0 still writes under reset
      for (int i = 0; i < 256; i++) begin
         d = $random(seed);
         m_dmem[i] = d;
         UUT.memory_stage.mem[i] = d;
      end
      model_reset();
      reset = 1'b0;
   endtask

   task automatic compare_retire(input proc_pkg::retire_t exp);
      check_field("retire.valid", retire.valid, exp.valid);
      check_field("retire.pc", retire.pc, exp.pc);
      check_field("retire.reg_write", retire.reg_write, exp.reg_write);
      if (exp.reg_write) begin
         check_field("retire.reg_addr", retire.reg_addr, exp.reg_addr);
         check_field("retire.reg_data", retire.reg_data, exp.reg_data);
      end
      check_field("retire.mem_write", retire.mem_write, exp.mem_write);
      if (exp.mem_write) begin
         check_field("retire.mem_addr", retire.mem_addr, exp.mem_addr);
         check_field("retire.mem_data", retire.mem_data, exp.mem_data);
      end
   endtask

   task automatic run_program(input int kind);
      proc_pkg::retire_t exp;
      int                retires;
      build_program(kind);
      load_and_reset();
      retires = 0;
      while (retires < run_retires && !m_halted) begin
         @(posedge clk);
         check_field("halted", halted, m_halted);
         check_field("err", err, m_err);
         model_step(exp);
         compare_retire(exp);
         retires++;
      end
      // Stopped core stays quiet until the next reset
      if (m_halted) begin
         repeat (halt_watch) begin
            @(posedge clk);
            check_field("retire.valid", retire.valid, 1'b0);
            check_field("halted", halted, 1'b1);
            check_field("err", err, m_err);
            check_field("retire.reg_write", retire.reg_write, 1'b0);
            check_field("retire.mem_write", retire.mem_write, 1'b0);
         end
      end
   endtask

   initial begin
      seed      = 32'hfadd_795d;
      reset     = 1'b1;
      load_en   = 1'b0;
      load_addr = '0;
      load_data = '0;
      for (int p = 0; p < num_programs; p++) begin
         run_program(p);
      end
      $display("TEST PASS");
      $finish;
   end

   initial begin
      #(wd_limit);
      $display("Run hung: the programs did not finish within the watchdog limit");
      report_failure();
   end

endmodule

/* dv/clock_gen.sv */
// Testbench clock source
// Free-running clock with a 4 ns period

`timescale 1ns/1ns

module clock_gen (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

endmodule

/* src/proc.sv */
// Single-cycle processor top
// Connects fetch, control, register file, ALU and data memory
// and presents one retire record per cycle

`timescale 1ns/1ns

module proc (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            load_en,
   input  logic [proc_pkg::addr_width-1:0] load_addr,
   input  logic [proc_pkg::data_width-1:0] load_data,
   output proc_pkg::retire_t               retire,
   output logic                            halted,
   output logic                            err
);

   // Datapath nets
   logic [proc_pkg::data_width-1:0]     pc;
   logic [proc_pkg::data_width-1:0]     pc_inc;
   logic [proc_pkg::data_width-1:0]     instr;
   logic [proc_pkg::data_width-1:0]     rs_data;
   logic [proc_pkg::data_width-1:0]     rt_data;
   logic [proc_pkg::data_width-1:0]     alu_result;
   logic [proc_pkg::data_width-1:0]     mem_data;
   logic [proc_pkg::data_width-1:0]     branch_target;
   logic [proc_pkg::data_width-1:0]     wr_data;
   logic [proc_pkg::reg_addr_width-1:0] wr_addr;
   logic                                take_branch;
   proc_pkg::ctrl_t                     ctrl;

   fetch_unit fetch_stage (
      .clk(clk), .reset(reset),
      .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
      .halted(halted), .take_branch(take_branch), .branch_target(branch_target),
      .pc(pc), .pc_inc(pc_inc), .instr(instr)
   );

   control_unit control_stage (
      .clk(clk), .reset(reset), .instr(instr),
      .ctrl(ctrl), .halted(halted), .err(err)
   );

   register_file reg_stage (
      .clk(clk), .reset(reset), .instr(instr), .ctrl(ctrl),
      .alu_result(alu_result), .mem_data(mem_data),
      .rs_data(rs_data), .rt_data(rt_data),
      .wr_addr(wr_addr), .wr_data(wr_data)
   );

   alu_unit execute_stage (
      .instr(instr), .ctrl(ctrl), .rs_data(rs_data), .rt_data(rt_data),
      .pc_inc(pc_inc), .alu_result(alu_result),
      .take_branch(take_branch), .branch_target(branch_target)
   );

   // Address is the low byte of the ALU sum
   data_memory memory_stage (
      .clk(clk), .mem_write(ctrl.mem_write),
      .addr(alu_result[proc_pkg::addr_width-1:0]),
      .write_data(rt_data), .read_data(mem_data)
   );

   // Retire record for the instruction held this cycle
   assign retire.valid     = !reset && !halted;
   assign retire.pc        = pc;
   assign retire.reg_write = ctrl.reg_write;
   assign retire.reg_addr  = wr_addr;
   assign retire.reg_data  = wr_data;
   assign retire.mem_write = ctrl.mem_write;
   assign retire.mem_addr  = alu_result[proc_pkg::addr_width-1:0];
   assign retire.mem_data  = rt_data;

endmodule

/* src/data_memory.sv */
// Data memory
// 256-word RAM, combinational read and write on the clock edge

`timescale 1ns/1ns

module data_memory (
   input  logic                            clk,
   input  logic                            mem_write,
   input  logic [proc_pkg::addr_width-1:0] addr,
   input  logic [proc_pkg::data_width-1:0] write_data,
   output logic [proc_pkg::data_width-1:0] read_data
);

   // Contents survive reset, preloaded from outside
   logic [proc_pkg::data_width-1:0] mem [proc_pkg::dmem_depth];

   assign read_data = mem[addr];

   always_ff @(posedge clk) begin
      if (mem_write) begin
         mem[addr] <= write_data;
      end
   end

endmodule

/* src/alu_unit.sv */
// ALU unit
// Operand B selection, add/and/xor with optional inversion
// and the branch condition and target computation

`timescale 1ns/1ns

module alu_unit (
   input  logic [proc_pkg::data_width-1:0] instr,
   input  proc_pkg::ctrl_t                 ctrl,
   input  logic [proc_pkg::data_width-1:0] rs_data,
   input  logic [proc_pkg::data_width-1:0] rt_data,
   input  logic [proc_pkg::data_width-1:0] pc_inc,
   output logic [proc_pkg::data_width-1:0] alu_result,
   output logic                            take_branch,
   output logic [proc_pkg::data_width-1:0] branch_target
);

   localparam int dw = proc_pkg::data_width;

   logic [dw-1:0] imm_ext;
   logic [dw-1:0] br_off_ext;
   logic [dw-1:0] j_off_ext;
   logic [dw-1:0] oprnd_b;
   logic [dw-1:0] b_eff;
   logic          rs_zero;

   assign imm_ext = {{(dw - proc_pkg::imm_width){instr[proc_pkg::imm_msb]}},
                     instr[proc_pkg::imm_msb:proc_pkg::imm_lsb]};

   assign oprnd_b = ctrl.use_imm ? imm_ext : rt_data;

   // Subtract as A + ~B + 1
   assign b_eff = ctrl.invert_b ? ~oprnd_b : oprnd_b;

   always_comb begin
      case (ctrl.alu_op)
         proc_pkg::alu_add: alu_result = rs_data + b_eff + dw'(ctrl.invert_b);
         proc_pkg::alu_and: alu_result = rs_data & b_eff;
         proc_pkg::alu_xor: alu_result = rs_data ^ b_eff;
         default:           alu_result = b_eff;
      endcase
   end

   // Branch offsets
   assign br_off_ext = {{(dw - proc_pkg::br_off_width){instr[proc_pkg::br_off_msb]}},
                        instr[proc_pkg::br_off_msb:proc_pkg::br_off_lsb]};
   assign j_off_ext  = {{(dw - proc_pkg::j_off_width){instr[proc_pkg::j_off_msb]}},
                        instr[proc_pkg::j_off_msb:proc_pkg::j_off_lsb]};

   assign rs_zero = (rs_data == '0);

   assign take_branch = (ctrl.branch_zero && rs_zero) ||
                        (ctrl.branch_nonzero && !rs_zero) ||
                        ctrl.jump;

   assign branch_target = pc_inc + (ctrl.jump ? j_off_ext : br_off_ext);

endmodule

/* src/register_file.sv */
// Register file
// Eight general registers with two read ports, destination
// selection and write-back source selection

`timescale 1ns/1ns

module register_file (
   input  logic                                clk,
   input  logic                                reset,
   input  logic [proc_pkg::data_width-1:0]     instr,
   input  proc_pkg::ctrl_t                     ctrl,
   input  logic [proc_pkg::data_width-1:0]     alu_result,
   input  logic [proc_pkg::data_width-1:0]     mem_data,
   output logic [proc_pkg::data_width-1:0]     rs_data,
   output logic [proc_pkg::data_width-1:0]     rt_data,
   output logic [proc_pkg::reg_addr_width-1:0] wr_addr,
   output logic [proc_pkg::data_width-1:0]     wr_data
);

   logic [proc_pkg::data_width-1:0]     regs [proc_pkg::reg_count];
   logic [proc_pkg::reg_addr_width-1:0] rs_addr;
   logic [proc_pkg::reg_addr_width-1:0] rt_addr;

   assign rs_addr = instr[proc_pkg::rs_msb:proc_pkg::rs_lsb];
   assign rt_addr = instr[proc_pkg::rt_msb:proc_pkg::rt_lsb];

   assign rs_data = regs[rs_addr];
   assign rt_data = regs[rt_addr];

   // I-type writes to bits 7..5, R-type to bits 4..2
   assign wr_addr = ctrl.dest_is_rt ? instr[proc_pkg::ird_msb:proc_pkg::ird_lsb]
                                    : instr[proc_pkg::rd_msb:proc_pkg::rd_lsb];

   assign wr_data = (ctrl.wb_src == proc_pkg::wb_mem) ? mem_data : alu_result;

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < proc_pkg::reg_count; i++) begin
            regs[i] <= '0;
         end
      end else if (ctrl.reg_write) begin
         regs[wr_addr] <= wr_data;
      end
   end

endmodule

/* src/control_unit.sv */
// Control unit
// Decodes the opcode into the control record, flags illegal
// opcodes and keeps the sticky halt and error state

`timescale 1ns/1ns

module control_unit (
   input  logic                            clk,
   input  logic                            reset,
   input  logic [proc_pkg::data_width-1:0] instr,
   output proc_pkg::ctrl_t                 ctrl,
   output logic                            halted,
   output logic                            err
);

   proc_pkg::opcode_e opcode;
   proc_pkg::ctrl_t   dec_ctrl;
   logic              illegal;
   logic              is_halt;

   assign opcode = proc_pkg::opcode_e'(instr[proc_pkg::op_msb:proc_pkg::op_lsb]);

   always_comb begin
      dec_ctrl = '{
         alu_op:         proc_pkg::alu_add,
         invert_b:       1'b0,
         use_imm:        1'b0,
         reg_write:      1'b0,
         dest_is_rt:     1'b0,
         wb_src:         proc_pkg::wb_alu,
         mem_write:      1'b0,
         branch_zero:    1'b0,
         branch_nonzero: 1'b0,
         jump:           1'b0
      };
      illegal = 1'b0;
      is_halt = 1'b0;
      case (opcode)
         proc_pkg::op_add: dec_ctrl.reg_write = 1'b1;
         proc_pkg::op_sub: begin
            dec_ctrl.reg_write = 1'b1;
            dec_ctrl.invert_b  = 1'b1;
         end
         proc_pkg::op_and: begin
            dec_ctrl.reg_write = 1'b1;
            dec_ctrl.alu_op    = proc_pkg::alu_and;
         end
         proc_pkg::op_xor: begin
            dec_ctrl.reg_write = 1'b1;
            dec_ctrl.alu_op    = proc_pkg::alu_xor;
         end
         proc_pkg::op_addi: begin
            dec_ctrl.use_imm    = 1'b1;
            dec_ctrl.reg_write  = 1'b1;
            dec_ctrl.dest_is_rt = 1'b1;
         end
         proc_pkg::op_ld: begin
            dec_ctrl.use_imm    = 1'b1;
            dec_ctrl.reg_write  = 1'b1;
            dec_ctrl.dest_is_rt = 1'b1;
            dec_ctrl.wb_src     = proc_pkg::wb_mem;
         end
         proc_pkg::op_st: begin
            dec_ctrl.use_imm   = 1'b1;
            dec_ctrl.mem_write = 1'b1;
         end
         proc_pkg::op_beqz: dec_ctrl.branch_zero    = 1'b1;
         proc_pkg::op_bnez: dec_ctrl.branch_nonzero = 1'b1;
         proc_pkg::op_j:    dec_ctrl.jump           = 1'b1;
         proc_pkg::op_nop:  ;
         proc_pkg::op_halt: is_halt = 1'b1;
         default:           illegal = 1'b1;
      endcase
   end

   // Nothing issues once stopped
   assign ctrl = halted ? proc_pkg::ctrl_t'('0) : dec_ctrl;

   // Only a live instruction may stop the core
   always_ff @(posedge clk) begin
      if (reset) begin
         halted <= 1'b0;
         err    <= 1'b0;
      end else if (!halted) begin
         if (is_halt || illegal) begin
            halted <= 1'b1;
         end
         if (illegal) begin
            err <= 1'b1;
         end
      end
   end

   halted_ctrl_quiet: assert property (
      @(posedge clk) disable iff (reset)
      halted |-> !(ctrl.reg_write || ctrl.mem_write || ctrl.branch_zero ||
                   ctrl.branch_nonzero || ctrl.jump)
   ) else $error("Control active while halted");

endmodule

/* src/fetch_unit.sv */
// Fetch unit
// Program counter, instruction memory with its load port
// and next-PC selection between sequential and branch targets

`timescale 1ns/1ns

module fetch_unit (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                load_en,
   input  logic [proc_pkg::addr_width-1:0]     load_addr,
   input  logic [proc_pkg::data_width-1:0]     load_data,
   input  logic                                halted,
   input  logic                                take_branch,
   input  logic [proc_pkg::data_width-1:0]     branch_target,
   output logic [proc_pkg::data_width-1:0]     pc,
   output logic [proc_pkg::data_width-1:0]     pc_inc,
   output logic [proc_pkg::data_width-1:0]     instr
);

   logic [proc_pkg::data_width-1:0] imem [proc_pkg::imem_depth];
   logic [proc_pkg::data_width-1:0] next_pc;

   // Program load, also accepted while reset is high
   always_ff @(posedge clk) begin
      if (load_en) begin
         imem[load_addr] <= load_data;
      end
   end

   // Word addressed, upper PC bits ignored by the array
   assign instr   = imem[pc[proc_pkg::addr_width-1:0]];
   assign pc_inc  = pc + proc_pkg::data_width'(1);
   assign next_pc = take_branch ? branch_target : pc_inc;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
      end else if (!halted) begin
         pc <= next_pc;
      end
   end

   // Frozen PC once the core has stopped
   pc_hold_when_halted: assert property (
      @(posedge clk) disable iff (reset)
      halted |=> $stable(pc)
   ) else $error("PC moved while halted");

endmodule

/* src/proc_pkg.sv */
// Processor package
// Word and memory sizes, instruction field positions, opcodes,
// control and retire records shared by the single-cycle core

package proc_pkg;

   // Machine sizes
   localparam int data_width     = 16;
   localparam int imem_depth     = 256;
   localparam int dmem_depth     = 256;
   localparam int reg_count      = 8;
   localparam int addr_width     = 8;
   localparam int reg_addr_width = 3;

   // Instruction field positions
   localparam int op_msb       = 15;
   localparam int op_lsb       = 11;
   localparam int rs_msb       = 10;
   localparam int rs_lsb       = 8;
   localparam int rt_msb       = 7;
   localparam int rt_lsb       = 5;
   localparam int rd_msb       = 4;
   localparam int rd_lsb       = 2;
   localparam int ird_msb      = 7;
   localparam int ird_lsb      = 5;
   localparam int imm_msb      = 4;
   localparam int imm_lsb      = 0;
   localparam int imm_width    = imm_msb - imm_lsb + 1;
   localparam int br_off_msb   = 7;
   localparam int br_off_lsb   = 0;
   localparam int br_off_width = br_off_msb - br_off_lsb + 1;
   localparam int j_off_msb    = 10;
   localparam int j_off_lsb    = 0;
   localparam int j_off_width  = j_off_msb - j_off_lsb + 1;

   // Any code outside this list is illegal
   typedef enum logic [4:0] {
      op_halt = 5'b00000,
      op_nop  = 5'b00001,
      op_j    = 5'b00100,
      op_addi = 5'b01000,
      op_beqz = 5'b01100,
      op_bnez = 5'b01101,
      op_st   = 5'b10000,
      op_ld   = 5'b10001,
      op_add  = 5'b11000,
      op_sub  = 5'b11001,
      op_and  = 5'b11010,
      op_xor  = 5'b11011
   } opcode_e;

   typedef enum logic [1:0] {
      alu_add    = 2'b00,
      alu_and    = 2'b01,
      alu_xor    = 2'b10,
      alu_pass_b = 2'b11
   } alu_op_e;

   typedef enum logic {
      wb_alu = 1'b0,
      wb_mem = 1'b1
   } wb_src_e;

   typedef struct packed {
      alu_op_e alu_op;
      logic    invert_b;
      logic    use_imm;
      logic    reg_write;
      logic    dest_is_rt;
      wb_src_e wb_src;
      logic    mem_write;
      logic    branch_zero;
      logic    branch_nonzero;
      logic    jump;
   } ctrl_t;

   // One record per retired instruction
   typedef struct packed {
      logic                      valid;
      logic [data_width-1:0]     pc;
      logic                      reg_write;
      logic [reg_addr_width-1:0] reg_addr;
      logic [data_width-1:0]     reg_data;
      logic                      mem_write;
      logic [addr_width-1:0]     mem_addr;
      logic [data_width-1:0]     mem_data;
   } retire_t;

endpackage
